//--- include/noncomp_cfg.svh
// Binary32 only; widths are fixed and the mantissa MSB marks a quiet NaN
`ifndef NONCOMP_CFG_SVH
`define NONCOMP_CFG_SVH

// Operand word and its fields
`define NC_FP_WIDTH 32
`define NC_EXP_BITS 8
`define NC_MAN_BITS 23

// One-hot class mask width
`define NC_CLASS_BITS 10

`endif

//--- design/noncomp_pkg.sv
// Types for the binary32 non-computational unit; only the NV flag is ever raised
`include "noncomp_cfg.svh"

package noncomp_pkg;

  // Operand and field vectors
  typedef logic [`NC_FP_WIDTH-1:0] fp_word_t;
  typedef logic [`NC_EXP_BITS-1:0] fp_exp_t;
  typedef logic [`NC_MAN_BITS-1:0] fp_man_t;

  // Exception flags {NV, DZ, OF, UF, NX}
  typedef logic [4:0] fflags_t;
  localparam int unsigned FLAG_NV = 4;

  // Operation groups
  typedef enum logic [1:0] {SGNJ, MINMAX, CMP, CLASSIFY} nc_op_e;

  // Rounding-mode field, doubles as sub-operation select
  typedef enum logic [2:0] {
    RNE = 3'b000, RTZ = 3'b001, RDN = 3'b010, RUP = 3'b011,
    RMM = 3'b100, ROD = 3'b101, DYN = 3'b111
  } rm_e;

  // One-hot class mask, bit 0 is negative infinity
  typedef enum logic [`NC_CLASS_BITS-1:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } classmask_e;

endpackage

//--- design/noncomp_info_if.sv
// Purely combinational operand facts; valid only while the operand inputs are stable
`timescale 1ns/10ps

interface noncomp_info_if;
  import noncomp_pkg::*;

  // Raw operands
  fp_word_t   operand_a;
  fp_word_t   operand_b;
  // NaN facts
  logic       nan_a;
  logic       nan_b;
  logic       any_nan;
  logic       any_snan;
  // Equal also covers +0 against -0
  logic       equal;
  // Strict sign-magnitude order, -0 below +0
  logic       a_smaller;
  classmask_e class_a;

  modport producer (output operand_a, operand_b, nan_a, nan_b, any_nan, any_snan,
                    equal, a_smaller, class_a);
  modport consumer (input  operand_a, operand_b, nan_a, nan_b, any_nan, any_snan,
                    equal, a_smaller, class_a);

endinterface

//--- design/fp_classifier.sv
// Zero latency decode of two binary32 operands; a_smaller is meaningless if either is NaN
`timescale 1ns/10ps
`include "noncomp_cfg.svh"

module fp_classifier (
  input  noncomp_pkg::fp_word_t operand_a_i,
  input  noncomp_pkg::fp_word_t operand_b_i,
  noncomp_info_if.producer      info
);
  import noncomp_pkg::*;

  // Index 0 is operand a, index 1 is operand b
  fp_word_t [1:0] op_w;
  fp_exp_t  [1:0] exp_f;
  fp_man_t  [1:0] man_f;
  logic     [1:0] sign, is_zero, is_sub, is_norm, is_inf, is_nan, is_snan;
  logic           mag_a_lt, mag_b_lt;

  assign op_w = {operand_b_i, operand_a_i};

  // ------------------------------------------------------------------------
  // Per-operand field split and category
  // ------------------------------------------------------------------------
  always_comb begin : decode_operands
    for (int i = 0; i < 2; i++) begin
      sign[i]    = op_w[i][`NC_FP_WIDTH-1];
      exp_f[i]   = op_w[i][`NC_FP_WIDTH-2 -: `NC_EXP_BITS];
      man_f[i]   = op_w[i][`NC_MAN_BITS-1:0];
      // Exponent all zero gives zero or subnormal
      is_zero[i] = (exp_f[i] == '0) && (man_f[i] == '0);
      is_sub[i]  = (exp_f[i] == '0) && (man_f[i] != '0);
      is_norm[i] = (exp_f[i] != '0) && (exp_f[i] != '1);
      // Exponent all ones gives infinity or NaN
      is_inf[i]  = (exp_f[i] == '1) && (man_f[i] == '0);
      is_nan[i]  = (exp_f[i] == '1) && (man_f[i] != '0);
      // Quiet bit clear means signalling
      is_snan[i] = is_nan[i] && !man_f[i][`NC_MAN_BITS-1];
    end
  end

  // ------------------------------------------------------------------------
  // Pairwise facts
  // ------------------------------------------------------------------------
  // Magnitude compare ignores the sign bit
  assign mag_a_lt = op_w[0][`NC_FP_WIDTH-2:0] < op_w[1][`NC_FP_WIDTH-2:0];
  assign mag_b_lt = op_w[1][`NC_FP_WIDTH-2:0] < op_w[0][`NC_FP_WIDTH-2:0];

  assign info.operand_a = operand_a_i;
  assign info.operand_b = operand_b_i;
  assign info.nan_a     = is_nan[0];
  assign info.nan_b     = is_nan[1];
  assign info.any_nan   = |is_nan;
  assign info.any_snan  = |is_snan;
  assign info.equal     = (operand_a_i == operand_b_i) || (&is_zero);
  // Differing signs: the negative one is smaller; both negative flips the order
  assign info.a_smaller = (sign[0] != sign[1]) ? sign[0] : (sign[0] ? mag_b_lt : mag_a_lt);

  // Class of operand a only
  always_comb begin : class_of_a
    if (is_norm[0])     info.class_a = sign[0] ? NEGNORM : POSNORM;
    else if (is_sub[0]) info.class_a = sign[0] ? NEGSUBNORM : POSSUBNORM;
    else if (is_zero[0]) info.class_a = sign[0] ? NEGZERO : POSZERO;
    else if (is_inf[0]) info.class_a = sign[0] ? NEGINF : POSINF;
    else                info.class_a = is_snan[0] ? SNAN : QNAN;
  end

endmodule

//--- design/fp_sgnj_minmax.sv
// Sign injection never flags; min/max is quiet, so only a signalling NaN raises NV
`timescale 1ns/10ps
`include "noncomp_cfg.svh"

module fp_sgnj_minmax (
  noncomp_info_if.consumer      info,
  input  noncomp_pkg::rm_e      rm_i,
  output noncomp_pkg::fp_word_t sgnj_result_o,
  output noncomp_pkg::fp_word_t minmax_result_o,
  output logic                  minmax_nv_o
);
  import noncomp_pkg::*;

  // Canonical quiet NaN, positive with only the quiet bit set
  localparam fp_word_t CANON_NAN = {1'b0, {`NC_EXP_BITS{1'b1}}, 1'b1,
                                    {(`NC_MAN_BITS-1){1'b0}}};

  logic sign_a, sign_b;

  assign sign_a = info.operand_a[`NC_FP_WIDTH-1];
  assign sign_b = info.operand_b[`NC_FP_WIDTH-1];

  // ------------------------------------------------------------------------
  // Sign injection, magnitude always from a
  // ------------------------------------------------------------------------
  always_comb begin : sign_inject
    sgnj_result_o = info.operand_a;
    unique case (rm_i)
      RNE:     sgnj_result_o[`NC_FP_WIDTH-1] = sign_b;           // SGNJ
      RTZ:     sgnj_result_o[`NC_FP_WIDTH-1] = ~sign_b;          // SGNJN
      RDN:     sgnj_result_o[`NC_FP_WIDTH-1] = sign_a ^ sign_b;  // SGNJX
      default: sgnj_result_o = info.operand_a;                   // RUP passthrough
    endcase
  end

  // ------------------------------------------------------------------------
  // Minimum and maximum
  // ------------------------------------------------------------------------
  // A tie only happens on bit-equal operands, so either pick returns a
  always_comb begin : min_max
    if (info.nan_a && info.nan_b)
      minmax_result_o = CANON_NAN;
    // A single NaN yields the other operand
    else if (info.nan_a)
      minmax_result_o = info.operand_b;
    else if (info.nan_b)
      minmax_result_o = info.operand_a;
    else if (rm_i == RTZ)
      minmax_result_o = info.a_smaller ? info.operand_b : info.operand_a;  // MAX
    else
      minmax_result_o = info.a_smaller ? info.operand_a : info.operand_b;  // MIN
  end

  assign minmax_nv_o = info.any_snan;

endmodule

//--- design/fp_compare.sv
// LE and LT signal on any NaN, EQ only on sNaN; boolean result sits in bit 0
`timescale 1ns/10ps

module fp_compare (
  noncomp_info_if.consumer      info,
  input  noncomp_pkg::rm_e      rm_i,
  input  logic                  op_mod_i,
  output noncomp_pkg::fp_word_t cmp_result_o,
  output logic                  cmp_nv_o
);
  import noncomp_pkg::*;

  logic cmp_bool;

  always_comb begin : compare
    cmp_bool = 1'b0;
    cmp_nv_o = 1'b0;
    // sNaN forces false regardless of op_mod
    if (info.any_snan) begin
      cmp_nv_o = 1'b1;
    end else begin
      unique case (rm_i)
        RNE: begin  // LE
          if (info.any_nan) cmp_nv_o = 1'b1;
          else cmp_bool = (info.a_smaller | info.equal) ^ op_mod_i;
        end
        RTZ: begin  // LT, -0 against +0 is not less
          if (info.any_nan) cmp_nv_o = 1'b1;
          else cmp_bool = (info.a_smaller & ~info.equal) ^ op_mod_i;
        end
        RDN: begin  // EQ, quiet NaN is never equal
          if (info.any_nan) cmp_bool = op_mod_i;
          else cmp_bool = info.equal ^ op_mod_i;
        end
        default: cmp_bool = 1'b0;
      endcase
    end
  end

  // Zero-extend into the result word
  assign cmp_result_o = fp_word_t'(cmp_bool);

endmodule

//--- design/noncomp_ctrl.sv
// Single output stage with valid/ready; flush drops the held item on the next edge
`timescale 1ns/10ps

module noncomp_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    in_valid_i,
  input  logic                    flush_i,
  input  logic                    out_ready_i,
  output logic                    in_ready_o,
  output logic                    out_valid_o,
  input  noncomp_pkg::nc_op_e     op_i,
  input  noncomp_pkg::fp_word_t   sgnj_result_i,
  input  noncomp_pkg::fp_word_t   minmax_result_i,
  input  noncomp_pkg::fp_word_t   cmp_result_i,
  input  logic                    minmax_nv_i,
  input  logic                    cmp_nv_i,
  noncomp_info_if.consumer        info,
  output noncomp_pkg::fp_word_t   result_o,
  output noncomp_pkg::fflags_t    status_o,
  output noncomp_pkg::classmask_e class_mask_o,
  output logic                    is_class_o
);
  import noncomp_pkg::*;

  fp_word_t   result_d, result_q;
  fflags_t    status_d, status_q;
  classmask_e class_mask_q;
  logic       is_class_d, is_class_q;
  logic       valid_q;
  logic       load;

  // ------------------------------------------------------------------------
  // Result selection
  // ------------------------------------------------------------------------
  always_comb begin : select_result
    result_d   = '0;
    status_d   = '0;
    is_class_d = 1'b0;
    unique case (op_i)
      SGNJ:   result_d = sgnj_result_i;
      MINMAX: begin
        result_d          = minmax_result_i;
        status_d[FLAG_NV] = minmax_nv_i;
      end
      CMP: begin
        result_d          = cmp_result_i;
        status_d[FLAG_NV] = cmp_nv_i;
      end
      // Class goes out on its own port, word and flags stay zero
      default: is_class_d = 1'b1;
    endcase
  end

  // ------------------------------------------------------------------------
  // Output stage
  // ------------------------------------------------------------------------
  // Stage can take a new item when empty or draining this cycle
  assign in_ready_o = out_ready_i | ~valid_q;
  assign load       = in_valid_i & in_ready_o;

  // Flush wins over a concurrent load
  always_ff @(posedge clk_i) begin : valid_reg
    if (!rst_n_i)        valid_q <= 1'b0;
    else if (flush_i)    valid_q <= 1'b0;
    else if (in_ready_o) valid_q <= in_valid_i;
  end

  // Payload only moves on accept, holds steady while stalled
  always_ff @(posedge clk_i) begin : payload_reg
    if (load) begin
      result_q     <= result_d;
      status_q     <= status_d;
      class_mask_q <= info.class_a;
      is_class_q   <= is_class_d;
    end
  end

  assign out_valid_o  = valid_q;
  assign result_o     = result_q;
  assign status_o     = status_q;
  assign class_mask_o = class_mask_q;
  assign is_class_o   = is_class_q;

endmodule

//--- design/noncomp_top.sv
// Binary32 non-computational FPU top; one-cycle latency, no side-band, no NaN-boxing
`timescale 1ns/10ps

module noncomp_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Operation request
  input  noncomp_pkg::fp_word_t   operand_a_i,
  input  noncomp_pkg::fp_word_t   operand_b_i,
  input  noncomp_pkg::rm_e        rm_i,
  input  noncomp_pkg::nc_op_e     op_i,
  input  logic                    op_mod_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  logic                    flush_i,
  // Result
  output noncomp_pkg::fp_word_t   result_o,
  output noncomp_pkg::fflags_t    status_o,
  output noncomp_pkg::classmask_e class_mask_o,
  output logic                    is_class_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i
);
  import noncomp_pkg::*;

  fp_word_t sgnj_result, minmax_result, cmp_result;
  logic     minmax_nv, cmp_nv;

  // Operand facts shared by every unit
  noncomp_info_if info_if ();

  fp_classifier fp_classifier_inst (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .info        (info_if.producer)
  );

  // ------------------------------------------------------------------------
  // Operation units, all combinational
  // ------------------------------------------------------------------------
  fp_sgnj_minmax fp_sgnj_minmax_inst (
    .info            (info_if.consumer),
    .rm_i            (rm_i),
    .sgnj_result_o   (sgnj_result),
    .minmax_result_o (minmax_result),
    .minmax_nv_o     (minmax_nv)
  );

  fp_compare fp_compare_inst (
    .info         (info_if.consumer),
    .rm_i         (rm_i),
    .op_mod_i     (op_mod_i),
    .cmp_result_o (cmp_result),
    .cmp_nv_o     (cmp_nv)
  );

  // Select and register
  noncomp_ctrl noncomp_ctrl_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .in_valid_i      (in_valid_i),
    .flush_i         (flush_i),
    .out_ready_i     (out_ready_i),
    .in_ready_o      (in_ready_o),
    .out_valid_o     (out_valid_o),
    .op_i            (op_i),
    .sgnj_result_i   (sgnj_result),
    .minmax_result_i (minmax_result),
    .cmp_result_i    (cmp_result),
    .minmax_nv_i     (minmax_nv),
    .cmp_nv_i        (cmp_nv),
    .info            (info_if.consumer),
    .result_o        (result_o),
    .status_o        (status_o),
    .class_mask_o    (class_mask_o),
    .is_class_o      (is_class_o)
  );

endmodule

//--- sim/noncomp_chk.sv
// Bound into noncomp_ctrl; payload is only checked while the output stage holds an item
`timescale 1ns/10ps

module noncomp_chk (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    flush_i,
  input logic                    out_ready_i,
  input logic                    in_ready_o,
  input logic                    out_valid_o,
  input noncomp_pkg::fp_word_t   result_o,
  input noncomp_pkg::fflags_t    status_o,
  input noncomp_pkg::classmask_e class_mask_o,
  input logic                    is_class_o
);

  // Reset leaves the stage empty
  reset_empty: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_o)
    else $error("output valid set right after reset");

  // Flush empties the stage on the next edge
  flush_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !out_valid_o)
    else $error("output valid set after flush");

  // Stalled item stays put
  stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> $stable(result_o) && $stable(status_o)
      && $stable(class_mask_o) && $stable(is_class_o))
    else $error("output payload changed under back-pressure");

  stall_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o)
    else $error("output valid dropped under back-pressure");

  ready_rule: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_ready_o == (out_ready_i || !out_valid_o))
    else $error("input ready does not follow output ready and valid");

  class_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && is_class_o |-> $onehot(class_mask_o))
    else $error("class mask is not one-hot");

endmodule

//--- sim/tb_noncomp.sv
// Random run of a fixed item count; expects one output stage and binary32 operands only
`timescale 1ns/10ps

module tb_noncomp;
  import noncomp_pkg::*;

  localparam int N_ITEMS         = 600;
  localparam int WATCHDOG_CYCLES = N_ITEMS * 20;
  localparam fp_word_t QNAN_WORD = 32'h7fc0_0000;

  typedef struct packed {
    fp_word_t   result;
    fflags_t    status;
    classmask_e cls;
    logic       is_class;
  } expect_t;

  logic clk_i = 1'b0;
  logic rst_n_i, in_valid_i, in_ready_o, flush_i, op_mod_i;
  logic out_valid_o, out_ready_i, is_class_o;
  fp_word_t   operand_a_i, operand_b_i, result_o;
  rm_e        rm_i;
  nc_op_e     op_i;
  fflags_t    status_o;
  classmask_e class_mask_o;

  expect_t exp_q[$];
  logic    fire_in = 1'b0;
  int      n_accepted = 0;

  noncomp_top noncomp_top_inst (.*);

  bind noncomp_ctrl noncomp_chk noncomp_chk_inst (.*);

  always #20 clk_i = ~clk_i;

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1);
  endtask

  // ------------------------------------------------------------------------
  // Compare tasks, one per result type
  // ------------------------------------------------------------------------
  task automatic check_word(string name, fp_word_t expv, fp_word_t actv);
    if (actv !== expv) begin
      $display("error at %0t: %s expected %h, got %h", $time, name, expv, actv);
      abort_run();
    end
  endtask

  task automatic check_flags(string name, fflags_t expv, fflags_t actv);
    if (actv !== expv) begin
      $display("error at %0t: %s expected %b, got %b", $time, name, expv, actv);
      abort_run();
    end
  endtask

  task automatic check_class(string name, classmask_e expv, classmask_e actv);
    if (actv !== expv) begin
      $display("error at %0t: %s expected %b, got %b", $time, name, expv, actv);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic expv, logic actv);
    if (actv !== expv) begin
      $display("error at %0t: %s expected %b, got %b", $time, name, expv, actv);
      abort_run();
    end
  endtask

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  function automatic logic nan_of(fp_word_t w);
    return (w[30:23] == 8'hff) && (w[22:0] != '0);
  endfunction

  function automatic classmask_e class_of(fp_word_t w);
    fp_exp_t ex;
    fp_man_t mn;
    ex = w[30:23];
    mn = w[22:0];
    if (ex == 8'hff && mn != '0) return mn[22] ? QNAN : SNAN;
    if (ex == 8'hff) return w[31] ? NEGINF : POSINF;
    if (ex == '0 && mn == '0) return w[31] ? NEGZERO : POSZERO;
    if (ex == '0) return w[31] ? NEGSUBNORM : POSSUBNORM;
    return w[31] ? NEGNORM : POSNORM;
  endfunction

  function automatic expect_t ref_noncomp(fp_word_t a, fp_word_t b, nc_op_e op, rm_e rm,
                                          logic mod);
    expect_t e;
    logic    na, nb, snan_any, lt, eq;
    na       = nan_of(a);
    nb       = nan_of(b);
    snan_any = (class_of(a) == SNAN) || (class_of(b) == SNAN);
    // Zeros of either sign are equal
    eq = (a == b) || ((a[30:0] == '0) && (b[30:0] == '0));
    // Sign-magnitude order, -0 below +0
    if (a[31] != b[31]) lt = a[31];
    else if (a[31]) lt = b[30:0] < a[30:0];
    else lt = a[30:0] < b[30:0];
    e = '{result: '0, status: '0, cls: class_of(a), is_class: 1'b0};
    case (op)
      SGNJ: begin
        e.result = a;
        if (rm == RNE) e.result[31] = b[31];
        else if (rm == RTZ) e.result[31] = ~b[31];
        else if (rm == RDN) e.result[31] = a[31] ^ b[31];
      end
      MINMAX: begin
        e.status[4] = snan_any;
        if (na && nb) e.result = QNAN_WORD;
        else if (na) e.result = b;
        else if (nb) e.result = a;
        // Min keeps a when smaller, max keeps a when not smaller
        else if (a == b || ((rm == RNE) == lt)) e.result = a;
        else e.result = b;
      end
      CMP: begin
        if (snan_any) e.status[4] = 1'b1;
        else if (rm == RDN) e.result[0] = (na || nb) ? mod : (eq ^ mod);
        else if (na || nb) e.status[4] = 1'b1;
        else if (rm == RNE) e.result[0] = (lt || eq) ^ mod;
        else e.result[0] = (lt && !eq) ^ mod;
      end
      default: e.is_class = 1'b1;
    endcase
    return e;
  endfunction

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  // Biased toward zeros, infinities, NaNs and subnormals
  function automatic fp_word_t pick_operand();
    fp_word_t w;
    logic     s;
    w = $urandom;
    s = w[31];
    case (3'($urandom))
      3'd0: w = {s, 31'h0};
      3'd1: w = {s, 8'hff, 23'h0};
      3'd2: w = {s, 8'hff, 1'b1, w[21:0]};
      3'd3: w = {s, 8'hff, 1'b0, w[21:1], 1'b1};
      3'd4: w = {s, 8'h00, w[22:1], 1'b1};
      default: ;
    endcase
    return w;
  endfunction

  task automatic load_random_item();
    operand_a_i = pick_operand();
    // Equal pairs and sign-flipped pairs now and then
    case (3'($urandom))
      3'd0: operand_b_i = operand_a_i;
      3'd1: operand_b_i = operand_a_i ^ 32'h8000_0000;
      default: operand_b_i = pick_operand();
    endcase
    op_i     = nc_op_e'(2'($urandom));
    op_mod_i = 1'($urandom);
    if (op_i == MINMAX) rm_i = rm_e'({2'b00, 1'($urandom)});
    else if (op_i == CMP) rm_i = (2'($urandom) == 2'b00) ? RDN : rm_e'({2'b00, 1'($urandom)});
    else rm_i = rm_e'({1'b0, 2'($urandom)});
  endtask

  initial begin : drive
    void'($urandom(32'h4a22_3bde));
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    out_ready_i = 1'b0;
    load_random_item();
    repeat (3) @(posedge clk_i);
    #2 rst_n_i = 1'b1;
    while (n_accepted < N_ITEMS) begin
      // A pending item holds until taken
      if (!in_valid_i || fire_in) begin
        in_valid_i = (2'($urandom) != 2'b00);
        load_random_item();
      end
      out_ready_i = (2'($urandom) != 2'b00);
      flush_i     = (6'($urandom) == 6'd0);
      @(posedge clk_i);
      #2;
    end
    // Drain the output stage
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    while (out_valid_o) begin
      @(posedge clk_i);
      #2;
    end
    @(negedge clk_i);
    if (exp_q.size() == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("%0d accepted items never came out", exp_q.size());
      abort_run();
    end
  end

  // ------------------------------------------------------------------------
  // Scoreboard, sampled mid-cycle for the coming edge
  // ------------------------------------------------------------------------
  always @(negedge clk_i) begin : scoreboard
    expect_t e;
    if (rst_n_i) begin
      // One stage, so valid is high exactly when one item is outstanding
      check_bit("out_valid_o", exp_q.size() != 0, out_valid_o);
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("output transfer at %0t with no item outstanding", $time);
          abort_run();
        end else begin
          e = exp_q.pop_front();
          check_word("result_o", e.result, result_o);
          check_flags("status_o", e.status, status_o);
          check_bit("is_class_o", e.is_class, is_class_o);
          if (e.is_class) check_class("class_mask_o", e.cls, class_mask_o);
        end
      end
      fire_in = in_valid_i && in_ready_o;
      if (fire_in) n_accepted++;
      // Flush drops the held item and anything loaded on the same edge
      if (flush_i) exp_q.delete();
      else if (fire_in) exp_q.push_back(ref_noncomp(operand_a_i, operand_b_i, op_i, rm_i,
                                                    op_mod_i));
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

endmodule

//--- flist.f
+incdir+include
design/noncomp_pkg.sv
design/noncomp_info_if.sv
design/fp_classifier.sv
design/fp_sgnj_minmax.sv
design/fp_compare.sv
design/noncomp_ctrl.sv
design/noncomp_top.sv
sim/noncomp_chk.sv
sim/tb_noncomp.sv

//--- Makefile
TOP = tb_noncomp

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

# Pass only if the testbench printed its pass line
sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
